//--- testbench/issue_stimulus.txt
# D test, per lane: valid sqN op(0 add 1 sub 2 and 3 xor 4 mul) dst srcA srcB immB imm(hex)
# B test branchSqN | E test tag expectedValue(hex)
D indep  1  1 0  1  0  0 1 0005   1  2 0  2  0  0 1 0007
D indep  1  3 3  3  0  0 1 00ff   1  4 0  4  0  0 1 1234
D chain  1  5 4  5  1  2 0 0000   1  6 0  6  5  0 1 0001
D chain  1  7 1  7  6  1 0 0000   1  8 4  8  7  4 0 0000
D chain  1  9 2  9  8  0 1 ff00   1 10 3 10  9  3 0 0000
D mulint 1 11 4 11  2  0 1 0100   1 12 0 12  1  0 1 0001
D mulint 1 13 0 13  2  0 1 0002   1 14 1 14  4  0 1 0004
D mulint 1 15 3 15  1  2 0 0000   1 16 4 16  4  1 0 0000
D fill   1 17 4 17 12 13 0 0000   1 18 4 18 17  0 1 0003
D fill   1 19 0 19 18  0 1 0001   1 20 0 20 18  0 1 0002
D fill   1 21 1 21 18  1 0 0000   1 22 2 22 18  0 1 000f
D fill   1 23 3 23 18  2 0 0000   1 24 0 24 19 20 0 0000
D fill   1 25 0 25 24 21 0 0000   1 26 1 26 25 22 0 0000
D fill   1 27 3 27 26 23 0 0000   1 28 0 28 27  0 1 0010
D branch 1 29 4 29 28  0 1 0002   1 30 0 30  1  0 1 0020
D branch 1 31 0 31 29  0 1 0001   1 32 3 32 29 30 0 0000
B branch 30
D branch 1 31 1 33 30  0 1 0005   1 32 0 34 29 33 0 0000
E chain  8 0002344c
E chain  10 000034ff
E mulint 11 00000700
E mulint 16 00005b04
E fill   22 00000002
E fill   28 00000157
E branch 30 00000025
E branch 34 000002ce

//--- sources.f
hw/issuePkg.sv
hw/resultBusIf.sv
hw/IssueQueue.sv
hw/RegFile.sv
hw/ExecPipe.sv
hw/IssueCore.sv
testbench/IssueCore_props.sv
testbench/tb_IssueCore.sv

//--- Bender.yml
package:
  name: issue_core

sources:
  - files:
      - hw/issuePkg.sv
      - hw/resultBusIf.sv
      - hw/IssueQueue.sv
      - hw/RegFile.sv
      - hw/ExecPipe.sv
      - hw/IssueCore.sv
  - target: test
    files:
      - testbench/IssueCore_props.sv
      - testbench/tb_IssueCore.sv

//--- testbench/tb_IssueCore.sv
`timescale 1ns/1ps

module tb_IssueCore;
    import issuePkg::*;

    localparam int QUEUE_SIZE = 8;
    localparam int DISPATCH_WIDTH = 2;
    localparam int MAX_LINES = 64;
    localparam int LANE_FIELDS = 8;

    logic clk;
    logic rst;
    logic [DISPATCH_WIDTH-1:0] dispatchValid;
    IssueUOp dispatchUop [DISPATCH_WIDTH];
    logic branchValid;
    SqN branchSqN;
    logic full;
    logic resultValid;
    Tag resultTag;
    SqN resultSqN;
    DataWord resultValue;

    // Stimulus lines in file order
    byte lineKind [MAX_LINES];
    string lineName [MAX_LINES];
    int lineField [MAX_LINES][2 * LANE_FIELDS];
    int lineCount;
    int expTag [MAX_LINES];
    DataWord expVal [MAX_LINES];
    string expName [MAX_LINES];
    int expCount;

    // Reference model, one slot per physical tag
    DataWord model [64];
    DataWord actual [64];
    SqN tagSqN [64];
    string tagTest [64];
    logic expected [64];
    logic flushed [64];
    logic seen [64];
    logic produced [64];

    int dispatched;
    int completed;
    int flushedCount;
    int cycles;
    int cycleLimit;
    logic fullSeen;

    IssueCore #(
        .QUEUE_SIZE(QUEUE_SIZE),
        .DISPATCH_WIDTH(DISPATCH_WIDTH)
    ) dut_i (
        .clk(clk),
        .rst(rst),
        .dispatchValid(dispatchValid),
        .dispatchUop(dispatchUop),
        .branchValid(branchValid),
        .branchSqN(branchSqN),
        .full(full),
        .resultValid(resultValid),
        .resultTag(resultTag),
        .resultSqN(resultSqN),
        .resultValue(resultValue)
    );

    task automatic stopWithFailure(input string why);
        $display("%0s", why);
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compareValue(input string name, input DataWord exp, input DataWord act);
        if (exp !== act) begin
            stopWithFailure($sformatf("Fail %0s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // a comes after b in program order, with wrap-around
    function automatic logic isYounger(input SqN a, input SqN b);
        logic signed [7:0] diff;
        diff = a - b;
        return diff > 0;
    endfunction

    function automatic DataWord applyOpcode(input int op, input DataWord a, input DataWord b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a ^ b;
            default: return a * b;
        endcase
    endfunction

    function automatic logic sourceReady(input Tag t);
        return t == '0 || produced[t] || (resultValid && resultTag == t);
    endfunction

    task automatic readStimulus();
        int fd;
        int got;
        string text;
        string kind;
        string name;
        int f [2 * LANE_FIELDS];
        DataWord value;
        fd = $fopen("testbench/issue_stimulus.txt", "r");
        if (fd == 0) begin
            stopWithFailure("Cannot open testbench/issue_stimulus.txt");
        end else begin
            while ($fgets(text, fd) > 0) begin
                kind = "";
                got = $sscanf(text, "%s", kind);
                if (got < 1 || kind[0] == "#") begin
                    continue;
                end
                if (kind == "D") begin
                    got = $sscanf(text,
                        "%s %s %d %d %d %d %d %d %d %h %d %d %d %d %d %d %d %h",
                        kind, name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
                        f[8], f[9], f[10], f[11], f[12], f[13], f[14], f[15]);
                    if (got != 18) begin
                        stopWithFailure($sformatf("Malformed dispatch line: %0s", text));
                    end
                end else if (kind == "B") begin
                    got = $sscanf(text, "%s %s %d", kind, name, f[0]);
                end else if (kind == "E") begin
                    got = $sscanf(text, "%s %s %d %h", kind, name, f[0], value);
                    expTag[expCount] = f[0];
                    expVal[expCount] = value;
                    expName[expCount] = name;
                    expCount++;
                    continue;
                end else begin
                    stopWithFailure($sformatf("Unknown stimulus line: %0s", text));
                end
                lineKind[lineCount] = kind[0];
                lineName[lineCount] = name;
                lineField[lineCount] = f;
                lineCount++;
            end
            $fclose(fd);
        end
    endtask

    // Model update in program order, lane 0 first
    task automatic recordGroup(input int i);
        int base;
        int dst;
        DataWord b;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            base = l * LANE_FIELDS;
            if (lineField[i][base] != 0) begin
                dst = lineField[i][base + 3];
                b = lineField[i][base + 6] != 0 ? DataWord'(lineField[i][base + 7] & 'hffff) :
                    model[lineField[i][base + 5]];
                model[dst] = applyOpcode(lineField[i][base + 2],
                    model[lineField[i][base + 4]], b);
                tagSqN[dst] = SqN'(lineField[i][base + 1]);
                tagTest[dst] = lineName[i];
                expected[dst] = 1'b1;
                dispatched++;
            end
        end
    endtask

    task automatic presentGroup(input int i);
        IssueUOp uop;
        int base;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            base = l * LANE_FIELDS;
            uop = '0;
            uop.sqN = SqN'(lineField[i][base + 1]);
            uop.opcode = Opcode'(3'(lineField[i][base + 2]));
            uop.fu = uop.opcode == MUL ? FU_MUL : FU_INT;
            uop.tagDst = Tag'(lineField[i][base + 3]);
            uop.tagA = Tag'(lineField[i][base + 4]);
            uop.tagB = Tag'(lineField[i][base + 5]);
            uop.availA = sourceReady(uop.tagA);
            uop.availB = sourceReady(uop.tagB);
            uop.immB = lineField[i][base + 6] != 0;
            uop.imm = 16'(lineField[i][base + 7]);
            dispatchUop[l] <= uop;
            dispatchValid[l] <= lineField[i][base] != 0;
        end
        branchValid <= 1'b0;
    endtask

    task automatic applyBranch(input int i);
        SqN sq;
        sq = SqN'(lineField[i][0]);
        dispatchValid <= '0;
        branchValid <= 1'b1;
        branchSqN <= sq;
        // A result on the bus before this edge is already committed
        for (int t = 1; t < 64; t++) begin
            if (expected[t] && !seen[t] && !(resultValid && resultTag == t) &&
                    isYounger(tagSqN[t], sq)) begin
                expected[t] = 1'b0;
                flushed[t] = 1'b1;
                flushedCount++;
            end
        end
        @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycleLimit) begin
            stopWithFailure($sformatf("Timeout: run did not finish in %0d cycles", cycleLimit));
        end
    end

    // Result bus monitor
    always @(posedge clk) begin
        if (dut_i.queue_i.props_i.failCount != 0) begin
            stopWithFailure("An assertion in the issue queue failed");
        end
        if (!rst) begin
            if (full) begin
                fullSeen = 1'b1;
            end
            if (resultValid) begin
                if (flushed[resultTag]) begin
                    stopWithFailure($sformatf("Tag %0d came from an op flushed by a branch",
                        resultTag));
                end
                if (!expected[resultTag] || seen[resultTag]) begin
                    stopWithFailure($sformatf("Unexpected or repeated result for tag %0d",
                        resultTag));
                end
                compareValue(tagTest[resultTag], model[resultTag], resultValue);
                compareValue(tagTest[resultTag], DataWord'(tagSqN[resultTag]),
                    DataWord'(resultSqN));
                seen[resultTag] = 1'b1;
                produced[resultTag] = 1'b1;
                actual[resultTag] = resultValue;
                completed++;
            end
        end
    end

    initial begin
        rst = 1'b1;
        dispatchValid = '0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            dispatchUop[l] = '0;
        end
        branchValid = 1'b0;
        branchSqN = '0;
        dispatched = 0;
        completed = 0;
        flushedCount = 0;
        cycles = 0;
        fullSeen = 1'b0;
        lineCount = 0;
        expCount = 0;
        for (int t = 0; t < 64; t++) begin
            model[t] = '0;
            actual[t] = '0;
            tagSqN[t] = '0;
            tagTest[t] = "";
            expected[t] = 1'b0;
            flushed[t] = 1'b0;
            seen[t] = 1'b0;
            produced[t] = 1'b0;
        end
        readStimulus();
        cycleLimit = 20 * (lineCount + expCount) + 100;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < lineCount; i++) begin
            if (lineKind[i] == "B") begin
                applyBranch(i);
            end else begin
                recordGroup(i);
                // Hold the group until the queue takes it
                do begin
                    presentGroup(i);
                    @(posedge clk);
                end while (full);
            end
        end
        dispatchValid <= '0;
        branchValid <= 1'b0;

        while (completed + flushedCount < dispatched) begin
            @(posedge clk);
        end
        // Flushed ops must stay silent while the pipe drains
        repeat (2 * MUL_LATENCY) @(posedge clk);

        for (int k = 0; k < expCount; k++) begin
            compareValue(expName[k], expVal[k], model[expTag[k]]);
            compareValue(expName[k], expVal[k], actual[expTag[k]]);
        end
        if (!fullSeen) begin
            stopWithFailure("The queue never reported full during back-to-back dispatch");
        end else if (dut_i.queue_i.props_i.failCount != 0) begin
            stopWithFailure("Assertions in the issue queue reported errors");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

//--- testbench/IssueCore_props.sv
`timescale 1ns/1ps

module IssueQueueProps #(
    parameter int QUEUE_SIZE = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input logic clk,
    input logic rst,
    input logic full,
    input logic issueValid,
    input logic doIssue,
    input logic issueIsInt,
    input issuePkg::IssueUOp issueEntry,
    input logic [DISPATCH_WIDTH-1:0] acceptValid,
    input issuePkg::IssueUOp dispatchUop [DISPATCH_WIDTH],
    input logic resultValid,
    input issuePkg::Tag resultTag,
    input logic [$clog2(QUEUE_SIZE):0] insertIndex
);
    import issuePkg::*;

    int failCount = 0;

    // Tags whose value is in the register file, pending once dispatched as a destination
    logic [63:0] written;
    logic srcAOk;
    logic srcBOk;

    always_ff @(posedge clk) begin
        if (rst) begin
            written <= '1;
        end else begin
            for (int l = 0; l < DISPATCH_WIDTH; l++) begin
                if (acceptValid[l]) begin
                    written[dispatchUop[l].tagDst] <= 1'b0;
                end
            end
            if (resultValid) begin
                written[resultTag] <= 1'b1;
            end
        end
    end

    assign srcAOk = written[issueEntry.tagA] ||
        (resultValid && resultTag == issueEntry.tagA);
    assign srcBOk = issueEntry.immB || written[issueEntry.tagB] ||
        (resultValid && resultTag == issueEntry.tagB);

    // Issue strobe comes out of reset low
    assert property (@(posedge clk) $past(rst) |-> !issueValid)
        else begin
            failCount++;
            $error("issueValid high in the cycle after reset");
        end

    assert property (@(posedge clk) disable iff (rst) doIssue |-> srcAOk && srcBOk)
        else begin
            failCount++;
            $error("Entry issued with an operand unavailable");
        end

    // A multiply owns the result bus slot that an INT issued two cycles later would use
    assert property (@(posedge clk) disable iff (rst)
            doIssue && !issueIsInt |-> ##2 !(doIssue && issueIsInt))
        else begin
            failCount++;
            $error("INT issue collides with a multiply on the result bus");
        end

    assert property (@(posedge clk) disable iff (rst)
            full |=> insertIndex <= $past(insertIndex))
        else begin
            failCount++;
            $error("Entries inserted while full");
        end

endmodule

bind IssueQueue IssueQueueProps #(
    .QUEUE_SIZE(QUEUE_SIZE),
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
) props_i (
    .clk(clk),
    .rst(rst),
    .full(full),
    .issueValid(issueValid),
    .doIssue(doIssue),
    .issueIsInt(queue[issueIdx].fu == issuePkg::FU_INT),
    .issueEntry(queue[issueIdx]),
    .acceptValid(dispatchValid & {DISPATCH_WIDTH{!full && !branchValid}}),
    .dispatchUop(dispatchUop),
    .resultValid(result.valid),
    .resultTag(result.tagDst),
    .insertIndex(insertIndex)
);

//--- hw/IssueCore.sv
`timescale 1ns/1ps

module IssueCore #(
    parameter int QUEUE_SIZE = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input logic clk,
    input logic rst,
    input logic [DISPATCH_WIDTH-1:0] dispatchValid,
    input issuePkg::IssueUOp dispatchUop [DISPATCH_WIDTH],
    input logic branchValid,
    input issuePkg::SqN branchSqN,
    output logic full,
    output logic resultValid,
    output issuePkg::Tag resultTag,
    output issuePkg::SqN resultSqN,
    output issuePkg::DataWord resultValue
);
    import issuePkg::*;

    logic issueValid;
    IssueUOp issueUop;
    Tag readTagA;
    Tag readTagB;
    DataWord readValueA;
    DataWord readValueB;

    resultBusIf resultBus ();

    IssueQueue #(
        .QUEUE_SIZE(QUEUE_SIZE),
        .DISPATCH_WIDTH(DISPATCH_WIDTH)
    ) queue_i (
        .clk(clk),
        .rst(rst),
        .dispatchValid(dispatchValid),
        .dispatchUop(dispatchUop),
        .branchValid(branchValid),
        .branchSqN(branchSqN),
        .result(resultBus.consumer),
        .full(full),
        .issueValid(issueValid),
        .issueUop(issueUop)
    );

    RegFile regFile_i (
        .clk(clk),
        .rst(rst),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .result(resultBus.consumer),
        .readValueA(readValueA),
        .readValueB(readValueB)
    );

    ExecPipe execPipe_i (
        .clk(clk),
        .rst(rst),
        .issueValid(issueValid),
        .issueUop(issueUop),
        .readValueA(readValueA),
        .readValueB(readValueB),
        .branchValid(branchValid),
        .branchSqN(branchSqN),
        .readTagA(readTagA),
        .readTagB(readTagB),
        .result(resultBus.producer)
    );

    assign resultValid = resultBus.valid;
    assign resultTag = resultBus.tagDst;
    assign resultSqN = resultBus.sqN;
    assign resultValue = resultBus.value;

endmodule

//--- hw/ExecPipe.sv
`timescale 1ns/1ps

module ExecPipe (
    input logic clk,
    input logic rst,
    input logic issueValid,
    input issuePkg::IssueUOp issueUop,
    input issuePkg::DataWord readValueA,
    input issuePkg::DataWord readValueB,
    input logic branchValid,
    input issuePkg::SqN branchSqN,
    output issuePkg::Tag readTagA,
    output issuePkg::Tag readTagB,
    resultBusIf.producer result
);
    import issuePkg::*;

    localparam int LAST = MUL_LATENCY - 1;

    DataWord opA;
    DataWord opB;
    DataWord aluOut;

    logic intValid;
    Tag intTag;
    SqN intSqN;
    DataWord intValue;

    logic [MUL_LATENCY-1:0] mulValid;
    Tag mulTag [MUL_LATENCY];
    SqN mulSqN [MUL_LATENCY];
    DataWord mulValue [MUL_LATENCY];
    DataWord mulOpB;

    function automatic logic killed(input logic brValid, input SqN brSqN, input SqN s);
        return brValid && !seqOlderEq(s, brSqN);
    endfunction

    assign readTagA = issueUop.tagA;
    assign readTagB = issueUop.tagB;
    assign opA = readValueA;
    assign opB = issueUop.immB ? {16'b0, issueUop.imm} : readValueB;

    always_comb begin
        case (issueUop.opcode)
            ADD: aluOut = opA + opB;
            SUB: aluOut = opA - opB;
            AND: aluOut = opA & opB;
            XOR: aluOut = opA ^ opB;
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        intValue <= aluOut;
        intTag <= issueUop.tagDst;
        intSqN <= issueUop.sqN;

        // Stage 0 latches operands, stage 1 multiplies, the rest just hold
        mulValue[0] <= opA;
        mulOpB <= opB;
        mulTag[0] <= issueUop.tagDst;
        mulSqN[0] <= issueUop.sqN;
        mulValue[1] <= mulValue[0] * mulOpB;
        for (int k = 2; k < MUL_LATENCY; k++) begin
            mulValue[k] <= mulValue[k - 1];
        end
        for (int k = 1; k < MUL_LATENCY; k++) begin
            mulTag[k] <= mulTag[k - 1];
            mulSqN[k] <= mulSqN[k - 1];
        end

        if (rst) begin
            intValid <= 1'b0;
            mulValid <= '0;
        end else begin
            intValid <= issueValid && issueUop.fu == FU_INT &&
                !killed(branchValid, branchSqN, issueUop.sqN);
            mulValid[0] <= issueValid && issueUop.fu == FU_MUL &&
                !killed(branchValid, branchSqN, issueUop.sqN);
            for (int k = 1; k < MUL_LATENCY; k++) begin
                mulValid[k] <= mulValid[k - 1] && !killed(branchValid, branchSqN, mulSqN[k - 1]);
            end
        end
    end

    // Queue reservation keeps both paths from landing together
    assign result.valid = (mulValid[LAST] && !killed(branchValid, branchSqN, mulSqN[LAST])) ||
        (intValid && !killed(branchValid, branchSqN, intSqN));
    assign result.tagDst = mulValid[LAST] ? mulTag[LAST] : intTag;
    assign result.sqN = mulValid[LAST] ? mulSqN[LAST] : intSqN;
    assign result.value = mulValid[LAST] ? mulValue[LAST] : intValue;

endmodule

//--- hw/RegFile.sv
`timescale 1ns/1ps

module RegFile (
    input logic clk,
    input logic rst,
    input issuePkg::Tag readTagA,
    input issuePkg::Tag readTagB,
    resultBusIf.consumer result,
    output issuePkg::DataWord readValueA,
    output issuePkg::DataWord readValueB
);
    import issuePkg::*;

    DataWord regs [64];

    function automatic DataWord readPort(input Tag tag);
        if (tag == '0) begin
            return '0;
        end
        // Bypass the write in flight
        if (result.valid && result.tagDst == tag) begin
            return result.value;
        end
        return regs[tag];
    endfunction

    assign readValueA = readPort(readTagA);
    assign readValueB = readPort(readTagB);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                regs[i] <= '0;
            end
        end else if (result.valid && result.tagDst != '0) begin
            regs[result.tagDst] <= result.value;
        end
    end

endmodule

//--- hw/IssueQueue.sv
`timescale 1ns/1ps

module IssueQueue #(
    parameter int QUEUE_SIZE = 8,
    parameter int DISPATCH_WIDTH = 2
) (
    input logic clk,
    input logic rst,
    input logic [DISPATCH_WIDTH-1:0] dispatchValid,
    input issuePkg::IssueUOp dispatchUop [DISPATCH_WIDTH],
    input logic branchValid,
    input issuePkg::SqN branchSqN,
    resultBusIf.consumer result,
    output logic full,
    output logic issueValid,
    output issuePkg::IssueUOp issueUop
);
    import issuePkg::*;

    localparam int IDX_W = $clog2(QUEUE_SIZE);

    // Entries in age order, oldest at index 0
    IssueUOp queue [QUEUE_SIZE];
    logic [IDX_W:0] insertIndex;
    logic [MUL_LATENCY-2:0] reservedWbs;
    logic [MUL_LATENCY-2:0] wbNext;

    logic [QUEUE_SIZE-1:0] readyA;
    logic [QUEUE_SIZE-1:0] readyB;
    logic issueFound;
    logic doIssue;
    logic [IDX_W-1:0] issueIdx;
    logic [IDX_W:0] flushIndex;

    logic [IDX_W:0] laneCount;
    logic [IDX_W:0] acceptCount;
    logic [IDX_W:0] laneSlot [DISPATCH_WIDTH];
    IssueUOp laneUop [DISPATCH_WIDTH];

    // Wakeup from the result bus
    always_comb begin
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            readyA[i] = queue[i].availA ||
                (result.valid && queue[i].tagA == result.tagDst);
            readyB[i] = queue[i].availB || queue[i].immB ||
                (result.valid && queue[i].tagB == result.tagDst);
        end
    end

    // Oldest ready entry wins
    always_comb begin
        issueFound = 1'b0;
        issueIdx = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (!issueFound && i < int'(insertIndex) && readyA[i] && readyB[i] &&
                    !(queue[i].fu == FU_INT && reservedWbs[0])) begin
                issueFound = 1'b1;
                issueIdx = IDX_W'(i);
            end
        end
    end

    assign doIssue = issueFound && !branchValid;

    // A multiply claims the result bus slot two cycles ahead
    always_comb begin
        wbNext = reservedWbs >> 1;
        if (doIssue && queue[issueIdx].fu == FU_MUL) begin
            wbNext[MUL_LATENCY-2] = 1'b1;
        end
    end

    // Keep everything at or before the branch
    always_comb begin
        flushIndex = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (i < int'(insertIndex) && seqOlderEq(queue[i].sqN, branchSqN)) begin
                flushIndex = (IDX_W + 1)'(i + 1);
            end
        end
    end

    always_comb begin
        logic [IDX_W:0] slot;
        slot = insertIndex - {{IDX_W{1'b0}}, doIssue};
        laneCount = '0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            laneSlot[l] = slot;
            laneUop[l] = dispatchUop[l];
            // Source may be on the bus right now
            if (result.valid && dispatchUop[l].tagA == result.tagDst) begin
                laneUop[l].availA = 1'b1;
            end
            if (result.valid && dispatchUop[l].tagB == result.tagDst) begin
                laneUop[l].availB = 1'b1;
            end
            if (dispatchValid[l]) begin
                slot = slot + 1'b1;
                laneCount = laneCount + 1'b1;
            end
        end
        full = int'(insertIndex) + int'(laneCount) > QUEUE_SIZE;
        acceptCount = full ? '0 : laneCount;
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            queue[i].availA <= readyA[i];
            queue[i].availB <= readyB[i];
        end

        if (rst) begin
            insertIndex <= '0;
            reservedWbs <= '0;
            issueValid <= 1'b0;
        end else if (branchValid) begin
            insertIndex <= flushIndex;
            reservedWbs <= wbNext;
            // Strobe ends, younger ops on the output are dropped in ExecPipe too
            issueValid <= 1'b0;
        end else begin
            reservedWbs <= wbNext;
            issueValid <= doIssue;
            if (doIssue) begin
                issueUop <= queue[issueIdx];
                issueUop.availA <= 1'b1;
                issueUop.availB <= 1'b1;
                for (int j = 0; j < QUEUE_SIZE - 1; j++) begin
                    if (j >= int'(issueIdx)) begin
                        queue[j] <= queue[j + 1];
                        queue[j].availA <= readyA[j + 1];
                        queue[j].availB <= readyB[j + 1];
                    end
                end
            end
            if (!full) begin
                for (int l = 0; l < DISPATCH_WIDTH; l++) begin
                    if (dispatchValid[l]) begin
                        queue[laneSlot[l][IDX_W-1:0]] <= laneUop[l];
                    end
                end
            end
            insertIndex <= insertIndex - {{IDX_W{1'b0}}, doIssue} + acceptCount;
        end
    end

endmodule

//--- hw/resultBusIf.sv
`timescale 1ns/1ps

interface resultBusIf;
    import issuePkg::*;

    logic valid;
    Tag tagDst;
    SqN sqN;
    DataWord value;

    modport producer (
        output valid,
        output tagDst,
        output sqN,
        output value
    );

    modport consumer (
        input valid,
        input tagDst,
        input sqN,
        input value
    );

endinterface

//--- hw/issuePkg.sv
package issuePkg;

    // Physical register tag, tag 0 is hardwired to zero
    typedef logic [5:0] Tag;

    // Program order sequence number, wraps around
    typedef logic [7:0] SqN;

    typedef logic [31:0] DataWord;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        AND,
        XOR,
        MUL
    } Opcode;

    typedef enum logic {
        FU_INT,
        FU_MUL
    } FuncUnit;

    typedef struct packed {
        Tag tagA;
        logic availA;
        Tag tagB;
        logic availB;
        logic [15:0] imm;
        logic immB;
        Tag tagDst;
        SqN sqN;
        Opcode opcode;
        FuncUnit fu;
    } IssueUOp;

    // Issue to result, multiply path
    localparam int MUL_LATENCY = 3;

    // True when a is at or before b in program order
    function automatic logic seqOlderEq(input SqN a, input SqN b);
        SqN diff;
        diff = a - b;
        return $signed(diff) <= 0;
    endfunction

endpackage
